//--- Makefile
SIM      := verilator
TOP      := tb_kernel_afu
FILELIST := kernel_afu.f
OBJ_DIR  := obj_dir
FLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
BIN      := $(OBJ_DIR)/V$(TOP)
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q '^=== PASS ===$$'

clean:
	rm -rf $(OBJ_DIR)

//--- dv/kernel_afu_sva.sv
/*
  Kernel top-level assertions
  Valid/ready hold rules on the m00_axi channels and the
  ap_ctrl_chain pulse and exclusivity rules
*/
`default_nettype none

module kernel_afu_sva (
  input logic ap_clk,
  input logic areset_m_axi,
  input logic ap_idle,
  input logic ap_ready,
  input logic ap_done,
  input logic arvalid,
  input logic arready,
  input logic rvalid,
  input logic rready,
  input logic awvalid,
  input logic awready,
  input logic wvalid,
  input logic wready,
  input logic bvalid,
  input logic bready
);
  timeunit 1ns;
  timeprecision 1ps;

  // --------------------------------------------------
  // Valid holds until ready
  // --------------------------------------------------
  a_ar_hold: assert property (@(posedge ap_clk) disable iff (areset_m_axi)
    arvalid && !arready |=> arvalid) else $error("arvalid dropped before arready");
  a_r_hold: assert property (@(posedge ap_clk) disable iff (areset_m_axi)
    rvalid && !rready |=> rvalid) else $error("rvalid dropped before rready");
  a_aw_hold: assert property (@(posedge ap_clk) disable iff (areset_m_axi)
    awvalid && !awready |=> awvalid) else $error("awvalid dropped before awready");
  a_w_hold: assert property (@(posedge ap_clk) disable iff (areset_m_axi)
    wvalid && !wready |=> wvalid) else $error("wvalid dropped before wready");
  a_b_hold: assert property (@(posedge ap_clk) disable iff (areset_m_axi)
    bvalid && !bready |=> bvalid) else $error("bvalid dropped before bready");

  // Host control rules
  a_ready_pulse: assert property (@(posedge ap_clk) disable iff (areset_m_axi)
    ap_ready |=> !ap_ready) else $error("ap_ready high for more than one cycle");
  a_done_idle: assert property (@(posedge ap_clk) disable iff (areset_m_axi)
    !(ap_done && ap_idle)) else $error("ap_done and ap_idle high together");

endmodule : kernel_afu_sva

`default_nettype wire

//--- dv/tb_clock_gen.sv
/*
  Testbench clock source
  10 ns ap_clk and a reset held for the first two cycles
*/
`default_nettype none

module tb_clock_gen (
  output logic ap_clk,
  output logic areset_m_axi
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    ap_clk = 1'b0;
    forever #5 ap_clk = ~ap_clk;          // 10 ns period
  end

  initial begin
    areset_m_axi = 1'b1;
    repeat (2) @(posedge ap_clk);         // Two reset edges
    areset_m_axi <= 1'b0;
  end

endmodule : tb_clock_gen

`default_nettype wire

//--- dv/tb_kernel_afu.sv
/*
  Reduction kernel testbench
  Host driver, valid/ready memory model with LFSR stalls,
  reference sum and a checker at each ap_done
*/
`default_nettype none

module tb_kernel_afu;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_JOBS    = 6;
  localparam int JOB_CYCLES  = 2000;       // Watchdog budget per job
  localparam int HOLD_CYCLES = 8;          // ap_done watched before ap_continue

  logic        ap_clk, areset_m_axi;
  logic        ap_start, ap_continue, ap_idle, ap_ready, ap_done;
  logic [63:0] buffer_0, buffer_1, buffer_2, buffer_3;
  logic        arvalid, arready, rvalid, rready, rlast;
  logic        awvalid, awready, wvalid, wready, wlast, bvalid, bready;
  logic [31:0] araddr, awaddr, rdata, wdata;
  logic [7:0]  arlen, awlen;
  logic [3:0]  wstrb;

  logic [31:0] mem [0:1023];               // Word-addressed memory
  logic [15:0] lfsr;
  int          rd_idx, rd_left, wr_idx;    // Burst in flight, write target
  logic [31:0] wr_data;
  logic        aw_got, w_got, r_take, b_take, done_q;
  int          errors, jobs_checked, exp_count, exp_src, chk_dst;
  logic [31:0] exp_total;
  string       test_name;

  tb_clock_gen i_clk (.ap_clk(ap_clk), .areset_m_axi(areset_m_axi));

  kernel_afu #(.ADDR_WIDTH(32)) i_dut (
    .ap_clk(ap_clk), .areset_m_axi(areset_m_axi),
    .ap_start(ap_start), .ap_continue(ap_continue),
    .buffer_0(buffer_0), .buffer_1(buffer_1), .buffer_2(buffer_2), .buffer_3(buffer_3),
    .ap_idle(ap_idle), .ap_ready(ap_ready), .ap_done(ap_done),
    .m00_axi_arvalid(arvalid), .m00_axi_arready(arready), .m00_axi_araddr(araddr),
    .m00_axi_arlen(arlen), .m00_axi_rvalid(rvalid), .m00_axi_rready(rready),
    .m00_axi_rdata(rdata), .m00_axi_rlast(rlast),
    .m00_axi_awvalid(awvalid), .m00_axi_awready(awready), .m00_axi_awaddr(awaddr),
    .m00_axi_awlen(awlen), .m00_axi_wvalid(wvalid), .m00_axi_wready(wready),
    .m00_axi_wdata(wdata), .m00_axi_wstrb(wstrb), .m00_axi_wlast(wlast),
    .m00_axi_bvalid(bvalid), .m00_axi_bready(bready)
  );

  bind kernel_afu kernel_afu_sva i_sva (
    .ap_clk(ap_clk), .areset_m_axi(areset_m_axi), .ap_idle(ap_idle),
    .ap_ready(ap_ready), .ap_done(ap_done),
    .arvalid(m00_axi_arvalid), .arready(m00_axi_arready),
    .rvalid(m00_axi_rvalid), .rready(m00_axi_rready),
    .awvalid(m00_axi_awvalid), .awready(m00_axi_awready),
    .wvalid(m00_axi_wvalid), .wready(m00_axi_wready),
    .bvalid(m00_axi_bvalid), .bready(m00_axi_bready)
  );

  // Galois LFSR, one step per bit
  function automatic logic lfsr_bit();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) lfsr = lfsr ^ 16'hB400;
    return out;
  endfunction

  function automatic logic [31:0] reverse_bytes(input logic [31:0] w);
    logic [31:0] r;
    int          b;
    for (b = 0; b < 4; b++) r[8*b +: 8] = w[8*(3-b) +: 8];
    return r;
  endfunction

  // Expected stored total, reordered on the way in and on the way out
  function automatic logic [31:0] expected_total(input int src, input int count,
                                                 input logic swap);
    logic [31:0] sum;
    int          i;
    sum = '0;
    for (i = 0; i < count; i++) sum += swap ? reverse_bytes(mem[src+i]) : mem[src+i];
    return swap ? reverse_bytes(sum) : sum;
  endfunction

  // --------------------------------------------------
  // Memory model
  // --------------------------------------------------
  always @(negedge ap_clk) begin
    if (areset_m_axi !== 1'b0) begin
      arready = 1'b0;
      awready = 1'b0;
      wready  = 1'b0;
      rvalid  = 1'b0;
      bvalid  = 1'b0;
      rd_left = 0;
      aw_got  = 1'b0;
      w_got   = 1'b0;
      r_take  = 1'b0;
      b_take  = 1'b0;
    end else begin
      if (r_take) begin                    // Beat taken at the last posedge
        rvalid = 1'b0;
        rd_idx++;
        rd_left--;
      end
      if (b_take) bvalid = 1'b0;
      if (aw_got && w_got && !bvalid) begin
        mem[wr_idx] = wr_data;
        aw_got      = 1'b0;
        w_got       = 1'b0;
        bvalid      = 1'b1;
      end
      arready = lfsr_bit();                // Stall when 0
      awready = lfsr_bit();
      wready  = lfsr_bit();
      if (!rvalid && rd_left > 0 && lfsr_bit()) begin
        rvalid = 1'b1;
        rdata  = mem[rd_idx];
        rlast  = (rd_left == 1);
      end
      // DUT outputs are flops, so these fire at the coming posedge
      if (arvalid && arready) begin
        rd_idx  = int'(araddr[11:2]);
        rd_left = int'(arlen) + 1;
        if (arlen !== 8'(exp_count - 1)) begin
          errors++;
          $display("FAIL %s arlen: expected %0d, actual %0d", test_name, exp_count - 1, arlen);
        end
        if (araddr !== 32'(exp_src)) begin
          errors++;
          $display("FAIL %s araddr: expected %h, actual %h", test_name, 32'(exp_src), araddr);
        end
      end
      if (awvalid && awready) begin
        wr_idx = int'(awaddr[11:2]);
        aw_got = 1'b1;
        if (awlen !== 8'd0) begin
          errors++;
          $display("FAIL %s awlen: expected 0, actual %0d", test_name, awlen);
        end
        if (awaddr !== 32'(chk_dst * 4)) begin
          errors++;
          $display("FAIL %s awaddr: expected %h, actual %h", test_name,
                   32'(chk_dst * 4), awaddr);
        end
      end
      if (wvalid && wready) begin
        wr_data = wdata;
        w_got   = 1'b1;
        if (wstrb !== 4'hF) begin
          errors++;
          $display("FAIL %s wstrb: expected f, actual %h", test_name, wstrb);
        end
        if (wlast !== 1'b1) begin
          errors++;
          $display("FAIL %s wlast: expected 1, actual %b", test_name, wlast);
        end
      end
      r_take = rvalid & rready;
      b_take = bvalid & bready;
    end
  end

  // Result check at each rising ap_done
  always @(negedge ap_clk) begin
    if (areset_m_axi !== 1'b0) begin
      done_q = 1'b0;
    end else begin
      if (ap_done && !done_q) begin
        jobs_checked++;
        if (mem[chk_dst] !== exp_total) begin
          errors++;
          $display("FAIL %s: expected %h, actual %h", test_name, exp_total, mem[chk_dst]);
        end
      end
      done_q = ap_done;
    end
  end

  // --------------------------------------------------
  // Host stimulus
  // --------------------------------------------------
  task automatic check_reset_state();
    if (ap_idle !== 1'b1 || ap_done !== 1'b0) begin
      errors++;
      $display("FAIL reset_ctrl: expected idle,done 10, actual %b%b", ap_idle, ap_done);
    end
    if ({ap_ready, arvalid, rready, awvalid, wvalid, bready} !== 6'b0) begin
      errors++;
      $display("FAIL reset_outputs: expected 000000, actual %b",
               {ap_ready, arvalid, rready, awvalid, wvalid, bready});
    end
  endtask

  task automatic run_job(input string name, input int src, input int dst,
                         input int count, input logic swap);
    test_name = name;
    exp_total = expected_total(src, count, swap);
    exp_count = count;
    exp_src   = src * 4;
    chk_dst   = dst;
    mem[dst]  = ~exp_total;                // Stale value that cannot match
    buffer_0  = 64'(src * 4);
    buffer_1  = 64'(dst * 4);
    buffer_2  = 64'(count);
    buffer_3  = {63'd0, swap};
    ap_start  = 1'b1;
    do @(negedge ap_clk); while (ap_ready !== 1'b1);
    ap_start = 1'b0;                       // Buffers held for capture
    do @(negedge ap_clk); while (ap_done !== 1'b1);
    repeat (HOLD_CYCLES) begin
      @(negedge ap_clk);
      if (ap_done !== 1'b1) begin
        errors++;
        $display("%s: ap_done fell before ap_continue was driven", name);
      end
    end
    ap_continue = 1'b1;
    @(negedge ap_clk);
    ap_continue = 1'b0;
    do @(negedge ap_clk); while (ap_idle !== 1'b1);
  endtask

  initial begin
    int i;
    ap_start     = 1'b0;
    ap_continue  = 1'b0;
    buffer_0     = '0;
    buffer_1     = '0;
    buffer_2     = '0;
    buffer_3     = '0;
    arready      = 1'b0;
    rvalid       = 1'b0;
    rdata        = '0;
    rlast        = 1'b0;
    awready      = 1'b0;
    wready       = 1'b0;
    bvalid       = 1'b0;
    lfsr         = 16'd37937;
    errors       = 0;
    jobs_checked = 0;
    exp_count    = 1;
    exp_src      = 0;
    chk_dst      = 0;
    exp_total    = '0;
    test_name    = "reset";
    for (i = 0; i < 1024; i++) mem[i] = (32'(i) * 32'h9E37_79B1) ^ (32'(i) << 22);
    wait (areset_m_axi === 1'b0);
    @(negedge ap_clk);
    check_reset_state();
    run_job("single_plain", 0, 900, 1, 1'b0);
    run_job("burst16_plain", 16, 901, 16, 1'b0);
    run_job("burst16_swap", 16, 902, 16, 1'b1);
    run_job("single_swap", 0, 903, 1, 1'b1);
    run_job("burst256_stall", 512, 904, 256, 1'b0);
    run_job("second_after_continue", 100, 905, 64, 1'b1);
    repeat (4) @(negedge ap_clk);
    if (jobs_checked != NUM_JOBS) begin
      errors++;
      $display("Only %0d of %0d jobs reached ap_done", jobs_checked, NUM_JOBS);
    end
    $display("Jobs checked: %0d, errors: %0d", jobs_checked, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (NUM_JOBS * JOB_CYCLES) @(posedge ap_clk);
    $display("Run did not finish within %0d cycles", NUM_JOBS * JOB_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

endmodule : tb_kernel_afu

`default_nettype wire

//--- kernel_afu.f
source/kernel_pkg.sv
source/kernel_ifs.sv
source/kernel_control.sv
source/axi_port_stage.sv
source/kernel_cu.sv
source/kernel_afu.sv
dv/tb_clock_gen.sv
dv/kernel_afu_sva.sv
dv/tb_kernel_afu.sv

//--- source/axi_port_stage.sv
/*
  Memory port stage
  Registers every read and write channel signal once in each
  direction. Readies and valids towards the CU carry the
  completed external transfer, so each beat is seen exactly once.
  Read and write data are byte swapped when endian is set.
*/
`default_nettype none

module axi_port_stage import kernel_pkg::*; #(
  parameter int ADDR_WIDTH = 32
) (
  input  logic        ap_clk,
  input  logic        areset_m_axi,
  input  logic        endian,
  mem_read_if.slave   cu_rd,     // From the compute unit
  mem_write_if.slave  cu_wr,
  mem_read_if.master  mem_rd,    // Towards memory
  mem_write_if.master mem_wr
);

  logic ar_fire, r_fire, aw_fire, w_fire, b_fire;
  logic ar_sent, aw_sent, w_sent; // External transfer done, CU valid still up

  assign ar_fire = mem_rd.arvalid & mem_rd.arready;
  assign r_fire  = mem_rd.rvalid & mem_rd.rready;
  assign aw_fire = mem_wr.awvalid & mem_wr.awready;
  assign w_fire  = mem_wr.wvalid & mem_wr.wready;
  assign b_fire  = mem_wr.bvalid & mem_wr.bready;

  // --------------------------------------------------
  // Read channels
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_m_axi) begin
      cu_rd.arready  <= 1'b0;
      cu_rd.rvalid   <= 1'b0;
      cu_rd.rdata    <= '0;
      cu_rd.rlast    <= 1'b0;
      mem_rd.arvalid <= 1'b0;
      mem_rd.araddr  <= {ADDR_WIDTH{1'b0}};
      mem_rd.arlen   <= '0;
      mem_rd.rready  <= 1'b0;
      ar_sent        <= 1'b0;
    end else begin
      cu_rd.arready  <= ar_fire;                        // Accept seen one cycle late
      cu_rd.rvalid   <= r_fire;                         // Only beats actually taken
      cu_rd.rdata    <= endian ? swap_bytes(mem_rd.rdata) : mem_rd.rdata;
      cu_rd.rlast    <= mem_rd.rlast;
      mem_rd.arvalid <= cu_rd.arvalid & ~ar_fire & ~ar_sent; // No second request
      mem_rd.araddr  <= cu_rd.araddr;
      mem_rd.arlen   <= cu_rd.arlen;
      mem_rd.rready  <= cu_rd.rready;
      ar_sent        <= ar_fire | (ar_sent & cu_rd.arvalid);
    end
  end

  // --------------------------------------------------
  // Write channels
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_m_axi) begin
      cu_wr.awready  <= 1'b0;
      cu_wr.wready   <= 1'b0;
      cu_wr.bvalid   <= 1'b0;
      mem_wr.awvalid <= 1'b0;
      mem_wr.awaddr  <= {ADDR_WIDTH{1'b0}};
      mem_wr.awlen   <= '0;
      mem_wr.wvalid  <= 1'b0;
      mem_wr.wdata   <= '0;
      mem_wr.wstrb   <= '0;
      mem_wr.wlast   <= 1'b0;
      mem_wr.bready  <= 1'b0;
      aw_sent        <= 1'b0;
      w_sent         <= 1'b0;
    end else begin
      cu_wr.awready  <= aw_fire;
      cu_wr.wready   <= w_fire;
      cu_wr.bvalid   <= b_fire;                         // One response per write
      mem_wr.awvalid <= cu_wr.awvalid & ~aw_fire & ~aw_sent;
      mem_wr.awaddr  <= cu_wr.awaddr;
      mem_wr.awlen   <= cu_wr.awlen;
      mem_wr.wvalid  <= cu_wr.wvalid & ~w_fire & ~w_sent;
      mem_wr.wdata   <= endian ? swap_bytes(cu_wr.wdata) : cu_wr.wdata;
      mem_wr.wstrb   <= cu_wr.wstrb;
      mem_wr.wlast   <= cu_wr.wlast;
      mem_wr.bready  <= cu_wr.bready;
      aw_sent        <= aw_fire | (aw_sent & cu_wr.awvalid);
      w_sent         <= w_fire | (w_sent & cu_wr.wvalid);
    end
  end

endmodule : axi_port_stage

`default_nettype wire

//--- source/kernel_afu.sv
/*
  Kernel top level
  Host control, compute unit and registered memory port
  stage, wired to plain host and m00_axi ports
*/
`default_nettype none

module kernel_afu import kernel_pkg::*; #(
  parameter int ADDR_WIDTH = 32
) (
  input  logic                  ap_clk,
  input  logic                  areset_m_axi,
  input  logic                  ap_start,
  input  logic                  ap_continue,
  input  logic [63:0]           buffer_0,
  input  logic [63:0]           buffer_1,
  input  logic [63:0]           buffer_2,
  input  logic [63:0]           buffer_3,
  output logic                  ap_idle,
  output logic                  ap_ready,
  output logic                  ap_done,
  // Read channels
  output logic                  m00_axi_arvalid,
  input  logic                  m00_axi_arready,
  output logic [ADDR_WIDTH-1:0] m00_axi_araddr,
  output burst_len_t            m00_axi_arlen,
  input  logic                  m00_axi_rvalid,
  output logic                  m00_axi_rready,
  input  word_t                 m00_axi_rdata,
  input  logic                  m00_axi_rlast,
  // Write channels
  output logic                  m00_axi_awvalid,
  input  logic                  m00_axi_awready,
  output logic [ADDR_WIDTH-1:0] m00_axi_awaddr,
  output burst_len_t            m00_axi_awlen,
  output logic                  m00_axi_wvalid,
  input  logic                  m00_axi_wready,
  output word_t                 m00_axi_wdata,
  output strb_t                 m00_axi_wstrb,
  output logic                  m00_axi_wlast,
  input  logic                  m00_axi_bvalid,
  output logic                  m00_axi_bready
);

  logic endian;  // Latched by control, used by the port stage

  // --------------------------------------------------
  // Interfaces
  // --------------------------------------------------
  cu_cmd_if    #(.ADDR_WIDTH(ADDR_WIDTH)) cmd ();
  mem_read_if  #(.ADDR_WIDTH(ADDR_WIDTH)) cu_rd ();   // CU side
  mem_write_if #(.ADDR_WIDTH(ADDR_WIDTH)) cu_wr ();
  mem_read_if  #(.ADDR_WIDTH(ADDR_WIDTH)) mem_rd ();  // Memory side
  mem_write_if #(.ADDR_WIDTH(ADDR_WIDTH)) mem_wr ();

  // Memory side to m00_axi ports
  assign m00_axi_arvalid = mem_rd.arvalid;
  assign m00_axi_araddr  = mem_rd.araddr;
  assign m00_axi_arlen   = mem_rd.arlen;
  assign m00_axi_rready  = mem_rd.rready;
  assign mem_rd.arready  = m00_axi_arready;
  assign mem_rd.rvalid   = m00_axi_rvalid;
  assign mem_rd.rdata    = m00_axi_rdata;
  assign mem_rd.rlast    = m00_axi_rlast;

  assign m00_axi_awvalid = mem_wr.awvalid;
  assign m00_axi_awaddr  = mem_wr.awaddr;
  assign m00_axi_awlen   = mem_wr.awlen;
  assign m00_axi_wvalid  = mem_wr.wvalid;
  assign m00_axi_wdata   = mem_wr.wdata;
  assign m00_axi_wstrb   = mem_wr.wstrb;
  assign m00_axi_wlast   = mem_wr.wlast;
  assign m00_axi_bready  = mem_wr.bready;
  assign mem_wr.awready  = m00_axi_awready;
  assign mem_wr.wready   = m00_axi_wready;
  assign mem_wr.bvalid   = m00_axi_bvalid;

  // --------------------------------------------------
  // Blocks
  // --------------------------------------------------
  kernel_control #(.ADDR_WIDTH(ADDR_WIDTH)) inst_kernel_control (
    .ap_clk      (ap_clk),
    .areset_m_axi(areset_m_axi),
    .ap_start    (ap_start),
    .ap_continue (ap_continue),
    .buffer_0    (buffer_0),
    .buffer_1    (buffer_1),
    .buffer_2    (buffer_2),
    .buffer_3    (buffer_3),
    .ap_idle     (ap_idle),
    .ap_ready    (ap_ready),
    .ap_done     (ap_done),
    .endian      (endian),
    .cmd         (cmd)
  );

  kernel_cu #(.ADDR_WIDTH(ADDR_WIDTH)) inst_kernel_cu (
    .ap_clk      (ap_clk),
    .areset_m_axi(areset_m_axi),
    .cmd         (cmd),
    .rd          (cu_rd),
    .wr          (cu_wr)
  );

  axi_port_stage #(.ADDR_WIDTH(ADDR_WIDTH)) inst_axi_port_stage (
    .ap_clk      (ap_clk),
    .areset_m_axi(areset_m_axi),
    .endian      (endian),
    .cu_rd       (cu_rd),
    .cu_wr       (cu_wr),
    .mem_rd      (mem_rd),
    .mem_wr      (mem_wr)
  );

endmodule : kernel_afu

`default_nettype wire

//--- source/kernel_control.sv
/*
  Kernel control
  ap_ctrl_chain FSM towards the host. Captures the buffer
  descriptor on the ap_ready cycle, starts the compute unit by
  four-phase req/ack and holds ap_done until ap_continue.
*/
`default_nettype none

module kernel_control import kernel_pkg::*; #(
  parameter int ADDR_WIDTH = 32
) (
  input  logic        ap_clk,
  input  logic        areset_m_axi,
  input  logic        ap_start,
  input  logic        ap_continue,
  input  logic [63:0] buffer_0,     // Source address
  input  logic [63:0] buffer_1,     // Destination address
  input  logic [63:0] buffer_2,     // Word count in low bits
  input  logic [63:0] buffer_3,     // Endian flag in bit 0
  output logic        ap_idle,
  output logic        ap_ready,
  output logic        ap_done,
  output logic        endian,
  cu_cmd_if.master    cmd
);

  ctrl_state_e state;
  logic        start_q;       // Registered ap_start
  logic        continue_q;    // Registered ap_continue
  logic        continue_seen; // ap_continue came before ack fell

  // --------------------------------------------------
  // Host handshake registers
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_m_axi) begin
      start_q    <= 1'b0;
      continue_q <= 1'b0;
    end else begin
      start_q    <= ap_start;
      continue_q <= ap_continue;
    end
  end

  // --------------------------------------------------
  // Control FSM
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_m_axi) begin
      state         <= CTRL_IDLE;
      ap_idle       <= 1'b1;
      ap_ready      <= 1'b0;
      ap_done       <= 1'b0;
      endian        <= 1'b0;
      cmd.req       <= 1'b0;
      continue_seen <= 1'b0;
    end else begin
      ap_ready <= 1'b0;                       // Single-cycle pulse
      case (state)
        CTRL_IDLE: begin
          if (start_q) begin
            ap_ready <= 1'b1;
            ap_idle  <= 1'b0;
            state    <= CTRL_START_CU;
          end
        end
        CTRL_START_CU: begin                  // ap_ready high here
          endian  <= buffer_3[0];             // Stable for the whole job
          cmd.req <= 1'b1;                    // Fields land on the same edge
          state   <= CTRL_WAIT_CU;
        end
        CTRL_WAIT_CU: begin
          if (cmd.ack) begin
            cmd.req <= 1'b0;                  // Phase 3 of req/ack
            ap_done <= 1'b1;
            state   <= CTRL_DONE;
          end
        end
        CTRL_DONE: begin
          if (continue_q) continue_seen <= 1'b1;
          // Leave only once the CU has dropped ack
          if ((continue_q || continue_seen) && !cmd.ack) begin
            ap_done       <= 1'b0;
            ap_idle       <= 1'b1;
            continue_seen <= 1'b0;
            state         <= CTRL_IDLE;
          end
        end
        default: state <= CTRL_IDLE;
      endcase
    end
  end

  // Descriptor capture on the ap_ready cycle
  always_ff @(posedge ap_clk) begin
    if (state == CTRL_START_CU) begin
      cmd.src_addr <= buffer_0[ADDR_WIDTH-1:0];
      cmd.dst_addr <= buffer_1[ADDR_WIDTH-1:0];
      cmd.count    <= buffer_2[8:0];          // Legal range 1 to 256
    end
  end

endmodule : kernel_control

`default_nettype wire

//--- source/kernel_cu.sv
/*
  Compute unit
  Reads count edge weights in one burst from src_addr, sums
  them modulo 2^32 and writes the total as a single beat to
  dst_addr. Acknowledges the job after the write response.
*/
`default_nettype none

module kernel_cu import kernel_pkg::*; #(
  parameter int ADDR_WIDTH = 32
) (
  input  logic        ap_clk,
  input  logic        areset_m_axi,
  cu_cmd_if.slave     cmd,
  mem_read_if.master  rd,
  mem_write_if.master wr
);

  cu_state_e   state;
  word_t       sum;        // Running total, wraps at 32 bits
  word_count_t beat_cnt;   // Beats accepted so far
  logic        aw_done;    // Write address taken
  logic        w_done;     // Write data taken
  logic        beat;       // Read beat accepted this cycle
  logic        last_beat;

  assign beat      = rd.rvalid & rd.rready;
  assign last_beat = rd.rlast | (beat_cnt == cmd.count - 9'd1);

  // --------------------------------------------------
  // Channel outputs, decoded from state
  // --------------------------------------------------
  assign rd.arvalid = (state == CU_READ_ADDR);
  assign rd.araddr  = cmd.src_addr[ADDR_WIDTH-1:0];
  assign rd.arlen   = burst_len_t'(cmd.count - 9'd1); // 256 words gives 255
  assign rd.rready  = (state == CU_READ_DATA);        // Held through the burst

  assign wr.awvalid = (state == CU_WRITE) & ~aw_done;
  assign wr.awaddr  = cmd.dst_addr[ADDR_WIDTH-1:0];
  assign wr.awlen   = '0;                             // Single beat
  assign wr.wvalid  = (state == CU_WRITE) & ~w_done;
  assign wr.wdata   = sum;
  assign wr.wstrb   = '1;
  assign wr.wlast   = 1'b1;
  assign wr.bready  = (state == CU_WRITE_RESP);

  assign cmd.ack    = (state == CU_ACK);

  // --------------------------------------------------
  // Job FSM
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_m_axi) begin
      state   <= CU_IDLE;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      case (state)
        CU_IDLE: begin
          if (cmd.req) state <= CU_READ_ADDR;
        end
        CU_READ_ADDR: begin
          if (rd.arvalid && rd.arready) state <= CU_READ_DATA;
        end
        CU_READ_DATA: begin
          if (beat && last_beat) state <= CU_WRITE;
        end
        CU_WRITE: begin                        // AW and W complete in any order
          if (wr.awvalid && wr.awready) aw_done <= 1'b1;
          if (wr.wvalid && wr.wready) w_done <= 1'b1;
          if ((aw_done || wr.awready) && (w_done || wr.wready)) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            state   <= CU_WRITE_RESP;
          end
        end
        CU_WRITE_RESP: begin
          if (wr.bvalid) state <= CU_ACK;
        end
        CU_ACK: begin
          if (!cmd.req) state <= CU_IDLE;      // Drop ack after req falls
        end
        default: state <= CU_IDLE;
      endcase
    end
  end

  // Accumulator and beat counter
  always_ff @(posedge ap_clk) begin
    if (state == CU_IDLE) begin
      sum      <= '0;
      beat_cnt <= '0;
    end else if (beat) begin
      sum      <= sum + rd.rdata;
      beat_cnt <= beat_cnt + 9'd1;
    end
  end

endmodule : kernel_cu

`default_nettype wire

//--- source/kernel_ifs.sv
/*
  Kernel interfaces
  Read port, write port and the compute command channel,
  each with a master and a slave modport
*/
`default_nettype none

// --------------------------------------------------
// Read address and read data channels
// --------------------------------------------------
interface mem_read_if import kernel_pkg::*; #(
  parameter int ADDR_WIDTH = 32
) ();
  logic                  arvalid;
  logic                  arready;
  logic [ADDR_WIDTH-1:0] araddr;
  burst_len_t            arlen;
  logic                  rvalid;
  logic                  rready;
  word_t                 rdata;
  logic                  rlast;

  modport master (
    output arvalid, araddr, arlen, rready,
    input  arready, rvalid, rdata, rlast
  );

  modport slave (
    input  arvalid, araddr, arlen, rready,
    output arready, rvalid, rdata, rlast
  );
endinterface : mem_read_if

// --------------------------------------------------
// Write address, write data and response channels
// --------------------------------------------------
interface mem_write_if import kernel_pkg::*; #(
  parameter int ADDR_WIDTH = 32
) ();
  logic                  awvalid;
  logic                  awready;
  logic [ADDR_WIDTH-1:0] awaddr;
  burst_len_t            awlen;
  logic                  wvalid;
  logic                  wready;
  word_t                 wdata;
  strb_t                 wstrb;
  logic                  wlast;
  logic                  bvalid;
  logic                  bready;

  modport master (
    output awvalid, awaddr, awlen, wvalid, wdata, wstrb, wlast, bready,
    input  awready, wready, bvalid
  );

  modport slave (
    input  awvalid, awaddr, awlen, wvalid, wdata, wstrb, wlast, bready,
    output awready, wready, bvalid
  );
endinterface : mem_write_if

// Job command, four-phase req/ack
interface cu_cmd_if import kernel_pkg::*; #(
  parameter int ADDR_WIDTH = 32
) ();
  logic                  req;
  logic                  ack;
  logic [ADDR_WIDTH-1:0] src_addr;
  logic [ADDR_WIDTH-1:0] dst_addr;
  word_count_t           count;

  modport master (output req, src_addr, dst_addr, count, input ack);
  modport slave  (input req, src_addr, dst_addr, count, output ack);
endinterface : cu_cmd_if

`default_nettype wire

//--- source/kernel_pkg.sv
/*
  Kernel package
  Word, strobe, burst and count types of the reduction kernel,
  the state encodings of both FSMs and the byte-order swap used
  at the memory boundary
*/
`default_nettype none

package kernel_pkg;

  // --------------------------------------------------
  // Data path types
  // --------------------------------------------------
  typedef logic [31:0] word_t;       // One memory data word
  typedef logic [3:0]  strb_t;       // One strobe bit per byte
  typedef logic [7:0]  burst_len_t;  // Beats minus one
  typedef logic [8:0]  word_count_t; // Words per job, 1 to 256

  // --------------------------------------------------
  // FSM encodings
  // --------------------------------------------------
  typedef enum logic [1:0] {
    CTRL_IDLE,     // Waiting for ap_start
    CTRL_START_CU, // ap_ready cycle, descriptor capture
    CTRL_WAIT_CU,  // req up, waiting for ack
    CTRL_DONE      // ap_done held until ap_continue
  } ctrl_state_e;

  typedef enum logic [2:0] {
    CU_IDLE,
    CU_READ_ADDR,  // Single read request
    CU_READ_DATA,  // Accumulating beats
    CU_WRITE,      // Address and data of the total
    CU_WRITE_RESP,
    CU_ACK         // Four-phase return
  } cu_state_e;

  // Reverse the byte order of one word
  function automatic word_t swap_bytes(input word_t data);
    return {data[7:0], data[15:8], data[23:16], data[31:24]};
  endfunction

endpackage : kernel_pkg

`default_nettype wire
